// ==== filelist.f ====
common/enet_pkg.sv
src/enet_intr_coalesce.sv
mdio/mdio_if.sv
src/enet_reg_if.sv
src/enet_core.sv
tb/enet_core_sva.sv
tb/enet_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the enet_core testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f filelist.f --top-module enet_core_tb -o enet_core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/enet_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== tb/enet_core_tb.sv ====
module enet_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MII_SPEED  = 2;
    localparam int FRAME_LEN  = enet_pkg::MDIO_PRE_BITS + enet_pkg::MDIO_FRAME_BITS;
    localparam int DATA_START = FRAME_LEN - enet_pkg::MMFR_DATA_W;
    localparam int RD_RELEASE = DATA_START - enet_pkg::MDIO_TA_BITS;

    typedef enum logic [2:0] {
        OP_WR,
        OP_RD,
        OP_TXEV,
        OP_RXEV,
        OP_WAITTO,
        OP_IRQ,
        OP_MDIO
    } op_e;

    typedef struct packed {
        int          tid;
        op_e         op;
        logic [11:0] addr;
        logic [31:0] data;
        logic [31:0] want;
    } row_t;

    logic        clk;
    logic        arst_n;
    logic        req_valid;
    logic        req_ready;
    logic        req_write;
    logic [11:0] req_addr;
    logic [31:0] req_wdata;
    logic        rsp_valid;
    logic        rsp_ready;
    logic [31:0] rsp_rdata;
    logic        tx_frame_done;
    logic        rx_frame_done;
    logic        irq;
    logic        mdc;
    logic        mdi = 1'b0;
    logic        mdo;
    logic        mdo_en;

    row_t        rows[$];
    string       test_name [1:6];
    int          errors = 0;
    int          test_errs = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          limit_cycles = 0;
    int          cyc = 0;
    int          evt_cyc = 0;
    int          rise_cnt = 0;
    int          frame_base = 0;
    logic        mdc_q = 1'b0;
    logic [15:0] phy_data = '0;
    logic        mdo_seen [FRAME_LEN];
    logic        en_seen [FRAME_LEN];

    enet_core i_enet_core (
        .clk           (clk          ),
        .arst_n        (arst_n       ),
        .req_valid     (req_valid    ),
        .req_ready     (req_ready    ),
        .req_write     (req_write    ),
        .req_addr      (req_addr     ),
        .req_wdata     (req_wdata    ),
        .rsp_valid     (rsp_valid    ),
        .rsp_ready     (rsp_ready    ),
        .rsp_rdata     (rsp_rdata    ),
        .tx_frame_done (tx_frame_done),
        .rx_frame_done (rx_frame_done),
        .irq           (irq          ),
        .mdc           (mdc          ),
        .mdi           (mdi          ),
        .mdo           (mdo          ),
        .mdo_en        (mdo_en       )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // PHY model records mdo after each rising mdc and drives mdi after each falling mdc
    always @(negedge clk) begin
        if (mdc && !mdc_q) begin
            if (rise_cnt - frame_base < FRAME_LEN) begin
                mdo_seen[rise_cnt - frame_base] = mdo;
                en_seen[rise_cnt - frame_base]  = mdo_en;
            end
            rise_cnt = rise_cnt + 1;
        end else if (!mdc && mdc_q) begin
            mdi = (rise_cnt - frame_base >= DATA_START && rise_cnt - frame_base < FRAME_LEN) ?
                  phy_data[FRAME_LEN - 1 - (rise_cnt - frame_base)] : 1'b0;
        end
        mdc_q = mdc;
    end

    task automatic report_error(input string msg);
        $display("ERROR @%0t: %s", $time, msg);
        errors++;
        test_errs++;
    endtask

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] want);
        assert (got === want) else begin
            $display("MISMATCH @%0t: %s is 0x%08h, expected 0x%08h", $time, what, got, want);
            errors++;
            test_errs++;
        end
    endtask

    task automatic add_row(input int tid, input op_e op, input logic [11:0] addr,
                           input logic [31:0] data, input logic [31:0] want);
        row_t r;
        r.tid  = tid;
        r.op   = op;
        r.addr = addr;
        r.data = data;
        r.want = want;
        rows.push_back(r);
    endtask

    // one register transfer, with a random number of rsp_ready stall cycles
    task automatic access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata);
        logic [31:0] first;
        int          stalls;
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = addr;
        req_wdata = wdata;
        while (!req_ready) @(negedge clk);
        @(negedge clk);
        req_valid = 1'b0;
        assert (rsp_valid === 1'b1) else
            report_error("no response one cycle after the request was accepted");
        assert (req_ready === 1'b0) else
            report_error("req_ready high while a response is pending");
        first  = rsp_rdata;
        stalls = $urandom % 4;
        repeat (stalls) begin
            @(negedge clk);
            assert (rsp_valid === 1'b1 && rsp_rdata === first) else
                report_error("response changed while rsp_ready was low");
            assert (req_ready === 1'b0) else
                report_error("req_ready high while a stalled response is pending");
        end
        rsp_ready = 1'b1;
        @(negedge clk);
        rsp_ready = 1'b0;
        assert (rsp_valid === 1'b0) else
            report_error("response still valid after it was taken");
        assert (req_ready === 1'b1) else
            report_error("req_ready low after the response was taken");
        rdata = first;
    endtask

    task automatic pulse_event(input logic is_tx);
        if (is_tx) tx_frame_done = 1'b1;
        else rx_frame_done = 1'b1;
        @(negedge clk);
        tx_frame_done = 1'b0;
        rx_frame_done = 1'b0;
        evt_cyc = cyc;
    endtask

    // next read samples EIR exactly `age` cycles after the last event edge
    task automatic wait_event_age(input int age);
        while (cyc - evt_cyc < age - 1) @(negedge clk);
        assert (cyc - evt_cyc == age - 1) else
            report_error($sformatf("timed read at %0d cycles came too late", age));
    endtask

    task automatic mdio_frame(input logic [31:0] word, input logic [15:0] value);
        logic        is_rd;
        logic        exp_en;
        logic        exp_bit;
        logic [31:0] got;
        is_rd      = (word[enet_pkg::MMFR_OP_LSB +: 2] == enet_pkg::MMFR_OP_READ);
        frame_base = rise_cnt;
        phy_data   = value;
        access(1'b1, enet_pkg::MMFR_ADDR, word, got);
        while (rise_cnt - frame_base < FRAME_LEN) @(negedge clk);
        while (mdc) @(negedge clk);
        // frame just ended, MII event follows one cycle later
        check_eq("irq as the frame ends", 32'(irq), 32'h0);
        @(negedge clk);
        check_eq("irq after the MII event", 32'(irq), 32'h1);
        for (int i = 0; i < FRAME_LEN; i++) begin
            exp_en = !(is_rd && i >= RD_RELEASE);
            check_eq($sformatf("mdo_en at frame bit %0d", i), 32'(en_seen[i]), 32'(exp_en));
            if (exp_en) begin
                exp_bit = (i < enet_pkg::MDIO_PRE_BITS) ? 1'b1 : word[FRAME_LEN - 1 - i];
                check_eq($sformatf("mdo at frame bit %0d", i), 32'(mdo_seen[i]), 32'(exp_bit));
            end
        end
        access(1'b0, enet_pkg::MMFR_ADDR, 32'h0, got);
        check_eq("MMFR after the frame", got, is_rd ? {word[31:16], value} : word);
    endtask

    task automatic run_row(input row_t r);
        logic [31:0] got;
        case (r.op)
            OP_WR: begin
                access(1'b1, r.addr, r.data, got);
                check_eq("write response data", got, 32'h0);
            end
            OP_RD: begin
                access(1'b0, r.addr, 32'h0, got);
                check_eq($sformatf("read of 0x%03h", r.addr), got, r.want);
            end
            OP_TXEV:   pulse_event(1'b1);
            OP_RXEV:   pulse_event(1'b0);
            OP_WAITTO: wait_event_age(r.data);
            OP_IRQ:    check_eq("irq", 32'(irq), r.want);
            OP_MDIO:   mdio_frame(r.data, r.want[15:0]);
            default:   report_error("unknown operation in the stimulus table");
        endcase
    endtask

    task automatic finish_test(input int tid);
        tests_run++;
        if (test_errs == 0) begin
            $display("test %0d (%s): passed", tid, test_name[tid]);
        end else begin
            tests_failed++;
            $display("test %0d (%s): failed with %0d errors", tid, test_name[tid], test_errs);
        end
        test_errs = 0;
    endtask

    task automatic build_table();
        // register access
        add_row(1, OP_RD, enet_pkg::EIR_ADDR, 32'h0, 32'h0);
        add_row(1, OP_RD, enet_pkg::EIMR_ADDR, 32'h0, 32'h0);
        add_row(1, OP_RD, enet_pkg::MSCR_ADDR, 32'h0, 32'h0);
        add_row(1, OP_WR, enet_pkg::EIMR_ADDR, 32'h1234_5678, 32'h0);
        add_row(1, OP_RD, enet_pkg::EIMR_ADDR, 32'h0, 32'h1234_5678);
        add_row(1, OP_WR, enet_pkg::MSCR_ADDR, 32'(MII_SPEED << enet_pkg::MSCR_SPEED_LSB), 32'h0);
        add_row(1, OP_RD, enet_pkg::MSCR_ADDR, 32'h0, 32'(MII_SPEED << enet_pkg::MSCR_SPEED_LSB));
        add_row(1, OP_WR, enet_pkg::TXIC_ADDR, 32'h8C30_1234, 32'h0);
        add_row(1, OP_RD, enet_pkg::TXIC_ADDR, 32'h0, 32'h8C30_1234);
        add_row(1, OP_WR, 12'h7FC, 32'hDEAD_BEEF, 32'h0);
        add_row(1, OP_RD, 12'h7FC, 32'h0, 32'h0);
        add_row(1, OP_RD, 12'h00C, 32'h0, 32'h0);
        // single tx event, masked and unmasked
        add_row(2, OP_WR, enet_pkg::TXIC_ADDR, 32'h0, 32'h0);
        add_row(2, OP_WR, enet_pkg::EIMR_ADDR, 32'h0, 32'h0);
        add_row(2, OP_TXEV, 12'h0, 32'h0, 32'h0);
        add_row(2, OP_RD, enet_pkg::EIR_ADDR, 32'h0, 32'h0800_0000);
        add_row(2, OP_IRQ, 12'h0, 32'h0, 32'h0);
        add_row(2, OP_WR, enet_pkg::EIMR_ADDR, 32'h0800_0000, 32'h0);
        add_row(2, OP_IRQ, 12'h0, 32'h0, 32'h1);
        add_row(2, OP_WR, enet_pkg::EIR_ADDR, 32'h0800_0000, 32'h0);
        add_row(2, OP_RD, enet_pkg::EIR_ADDR, 32'h0, 32'h0);
        add_row(2, OP_IRQ, 12'h0, 32'h0, 32'h0);
        // rx count threshold 3
        add_row(3, OP_WR, enet_pkg::RXIC_ADDR, 32'h8030_0000, 32'h0);
        add_row(3, OP_RXEV, 12'h0, 32'h0, 32'h0);
        add_row(3, OP_RXEV, 12'h0, 32'h0, 32'h0);
        add_row(3, OP_RD, enet_pkg::EIR_ADDR, 32'h0, 32'h0);
        add_row(3, OP_RXEV, 12'h0, 32'h0, 32'h0);
        add_row(3, OP_RD, enet_pkg::EIR_ADDR, 32'h0, 32'h0200_0000);
        add_row(3, OP_WR, enet_pkg::EIR_ADDR, 32'h0200_0000, 32'h0);
        add_row(3, OP_RD, enet_pkg::EIR_ADDR, 32'h0, 32'h0);
        // tx timer 40 cycles, count threshold 200 out of reach
        add_row(4, OP_WR, enet_pkg::TXIC_ADDR, 32'h8C80_0028, 32'h0);
        add_row(4, OP_TXEV, 12'h0, 32'h0, 32'h0);
        add_row(4, OP_WAITTO, 12'h0, 32'd20, 32'h0);
        add_row(4, OP_RD, enet_pkg::EIR_ADDR, 32'h0, 32'h0);
        add_row(4, OP_WAITTO, 12'h0, 32'd41, 32'h0);
        add_row(4, OP_RD, enet_pkg::EIR_ADDR, 32'h0, 32'h0800_0000);
        add_row(4, OP_IRQ, 12'h0, 32'h0, 32'h1);
        add_row(4, OP_WR, enet_pkg::EIR_ADDR, 32'h0800_0000, 32'h0);
        // management frames
        add_row(5, OP_WR, enet_pkg::EIMR_ADDR, 32'h0080_0000, 32'h0);
        add_row(5, OP_MDIO, 12'h0, 32'h5086_ABCD, 32'h0);
        add_row(5, OP_RD, enet_pkg::EIR_ADDR, 32'h0, 32'h0080_0000);
        add_row(5, OP_WR, enet_pkg::EIR_ADDR, 32'h0080_0000, 32'h0);
        add_row(5, OP_RD, enet_pkg::EIR_ADDR, 32'h0, 32'h0);
        add_row(6, OP_MDIO, 12'h0, 32'h6086_0000, 32'h0000_C35A);
        add_row(6, OP_RD, enet_pkg::EIR_ADDR, 32'h0, 32'h0080_0000);
        add_row(6, OP_WR, enet_pkg::EIR_ADDR, 32'h0080_0000, 32'h0);
    endtask

    initial begin
        int n_mdio;
        req_valid     = 1'b0;
        req_write     = 1'b0;
        req_addr      = '0;
        req_wdata     = '0;
        rsp_ready     = 1'b0;
        tx_frame_done = 1'b0;
        rx_frame_done = 1'b0;
        arst_n        = 1'b0;
        void'($urandom(32'h9df6bbbc));
        test_name[1] = "register access";
        test_name[2] = "uncoalesced events";
        test_name[3] = "count coalescing";
        test_name[4] = "timer coalescing";
        test_name[5] = "mdio write";
        test_name[6] = "mdio read";
        build_table();
        n_mdio = 0;
        foreach (rows[i]) begin
            if (rows[i].op == OP_MDIO) n_mdio++;
        end
        limit_cycles = rows.size() * 64 + n_mdio * FRAME_LEN * 2 * MII_SPEED + 500;

        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_eq("rsp_valid after reset", 32'(rsp_valid), 32'h0);
        check_eq("irq after reset", 32'(irq), 32'h0);
        check_eq("mdc after reset", 32'(mdc), 32'h0);
        check_eq("mdo_en after reset", 32'(mdo_en), 32'h0);

        foreach (rows[i]) begin
            if (i > 0 && rows[i].tid != rows[i-1].tid) finish_test(rows[i-1].tid);
            run_row(rows[i]);
        end
        finish_test(rows[rows.size()-1].tid);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        @(posedge arst_n);
        repeat (limit_cycles) @(posedge clk);
        $display("ERROR @%0t: run did not finish within %0d cycles", $time, limit_cycles);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== tb/enet_core_sva.sv ====
module enet_core_sva (
    input logic                        clk,
    input logic                        arst_n,
    input logic                        req_ready,
    input logic                        rsp_valid,
    input logic                        rsp_ready,
    input logic [enet_pkg::DATA_W-1:0] rsp_rdata,
    input logic                        mdc,
    input logic                        mdo_en,
    input logic                        mdio_busy
);

    timeunit 1ns;
    timeprecision 1ps;

    // a pending response holds until it is taken
    a_rsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata))
        else $error("response changed under back-pressure");

    a_one_in_flight: assert property (@(posedge clk) disable iff (!arst_n)
        !(req_ready && rsp_valid))
        else $error("request accepted while a response is pending");

    a_mdio_idle: assert property (@(posedge clk) disable iff (!arst_n)
        !mdio_busy |-> !mdo_en && !mdc)
        else $error("mdio outputs active while the engine is idle");

    // no mdc edge follows an idle cycle
    a_mdc_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        !mdio_busy |=> $stable(mdc))
        else $error("mdc toggled while the engine is idle");

endmodule

bind enet_core enet_core_sva i_enet_core_sva (
    .clk       (clk             ),
    .arst_n    (arst_n          ),
    .req_ready (req_ready       ),
    .rsp_valid (rsp_valid       ),
    .rsp_ready (rsp_ready       ),
    .rsp_rdata (rsp_rdata       ),
    .mdc       (mdc             ),
    .mdo_en    (mdo_en          ),
    .mdio_busy (u_mdio_if.busy  )
);

// ==== src/enet_core.sv ====
module enet_core (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        req_valid,
    output logic                        req_ready,
    input  logic                        req_write,
    input  logic [enet_pkg::ADDR_W-1:0] req_addr,
    input  logic [enet_pkg::DATA_W-1:0] req_wdata,
    output logic                        rsp_valid,
    input  logic                        rsp_ready,
    output logic [enet_pkg::DATA_W-1:0] rsp_rdata,
    input  logic                        tx_frame_done,
    input  logic                        rx_frame_done,
    output logic                        irq,
    output logic                        mdc,
    input  logic                        mdi,
    output logic                        mdo,
    output logic                        mdo_en
);

    logic [enet_pkg::DATA_W-1:0] wdata;
    logic [enet_pkg::DATA_W-1:0] txic;
    logic [enet_pkg::DATA_W-1:0] rxic;
    logic [enet_pkg::DATA_W-1:0] mmfr;
    logic [enet_pkg::DATA_W-1:0] mscr;
    logic                        txic_wen;
    logic                        rxic_wen;
    logic                        mmfr_wen;
    logic                        mscr_wen;
    logic                        txf_clear;
    logic                        rxf_clear;
    logic                        txf;
    logic                        rxf;
    logic                        mii_done;

    enet_reg_if u_enet_reg_if (
        .clk        (clk        ),
        .arst_n     (arst_n     ),
        .req_valid  (req_valid  ),
        .req_ready  (req_ready  ),
        .req_write  (req_write  ),
        .req_addr   (req_addr   ),
        .req_wdata  (req_wdata  ),
        .rsp_valid  (rsp_valid  ),
        .rsp_ready  (rsp_ready  ),
        .rsp_rdata  (rsp_rdata  ),
        .txf        (txf        ),
        .rxf        (rxf        ),
        .mii_done   (mii_done   ),
        .txic       (txic       ),
        .rxic       (rxic       ),
        .mmfr       (mmfr       ),
        .mscr       (mscr       ),
        .wdata      (wdata      ),
        .txic_wen   (txic_wen   ),
        .rxic_wen   (rxic_wen   ),
        .mmfr_wen   (mmfr_wen   ),
        .mscr_wen   (mscr_wen   ),
        .txf_clear  (txf_clear  ),
        .rxf_clear  (rxf_clear  ),
        .irq        (irq        )
    );

    enet_intr_coalesce u_tx_intr_coalesce (
        .clk        (clk            ),
        .arst_n     (arst_n         ),
        .cfg_wen    (txic_wen       ),
        .wdata      (wdata          ),
        .event_in   (tx_frame_done  ),
        .clear      (txf_clear      ),
        .cfg        (txic           ),
        .flag       (txf            )
    );

    enet_intr_coalesce u_rx_intr_coalesce (
        .clk        (clk            ),
        .arst_n     (arst_n         ),
        .cfg_wen    (rxic_wen       ),
        .wdata      (wdata          ),
        .event_in   (rx_frame_done  ),
        .clear      (rxf_clear      ),
        .cfg        (rxic           ),
        .flag       (rxf            )
    );

    mdio_if u_mdio_if (
        .clk        (clk        ),
        .arst_n     (arst_n     ),
        .mmfr_wen   (mmfr_wen   ),
        .mscr_wen   (mscr_wen   ),
        .wdata      (wdata      ),
        .mdi        (mdi        ),
        .mmfr       (mmfr       ),
        .mscr       (mscr       ),
        .done       (mii_done   ),
        .mdc        (mdc        ),
        .mdo        (mdo        ),
        .mdo_en     (mdo_en     )
    );

endmodule

// ==== src/enet_reg_if.sv ====
module enet_reg_if (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        req_valid,
    output logic                        req_ready,
    input  logic                        req_write,
    input  logic [enet_pkg::ADDR_W-1:0] req_addr,
    input  logic [enet_pkg::DATA_W-1:0] req_wdata,
    output logic                        rsp_valid,
    input  logic                        rsp_ready,
    output logic [enet_pkg::DATA_W-1:0] rsp_rdata,
    input  logic                        txf,
    input  logic                        rxf,
    input  logic                        mii_done,
    input  logic [enet_pkg::DATA_W-1:0] txic,
    input  logic [enet_pkg::DATA_W-1:0] rxic,
    input  logic [enet_pkg::DATA_W-1:0] mmfr,
    input  logic [enet_pkg::DATA_W-1:0] mscr,
    output logic [enet_pkg::DATA_W-1:0] wdata,
    output logic                        txic_wen,
    output logic                        rxic_wen,
    output logic                        mmfr_wen,
    output logic                        mscr_wen,
    output logic                        txf_clear,
    output logic                        rxf_clear,
    output logic                        irq
);

    enet_pkg::reg_sel_e          sel;
    logic                        req_fire;
    logic                        wr_fire;
    logic                        eir_wen;
    logic                        eimr_wen;
    logic                        mii;
    logic [enet_pkg::DATA_W-1:0] eimr;
    logic [enet_pkg::DATA_W-1:0] eir;
    logic [enet_pkg::DATA_W-1:0] rdata_mux;

    always_comb begin
        case (req_addr)
            enet_pkg::EIR_ADDR:  sel = enet_pkg::SEL_EIR;
            enet_pkg::EIMR_ADDR: sel = enet_pkg::SEL_EIMR;
            enet_pkg::MMFR_ADDR: sel = enet_pkg::SEL_MMFR;
            enet_pkg::MSCR_ADDR: sel = enet_pkg::SEL_MSCR;
            enet_pkg::TXIC_ADDR: sel = enet_pkg::SEL_TXIC;
            enet_pkg::RXIC_ADDR: sel = enet_pkg::SEL_RXIC;
            default:             sel = enet_pkg::SEL_NONE;
        endcase
    end

    // one request in flight, accepted only with no response pending
    assign req_ready = !rsp_valid;
    assign req_fire  = req_valid && req_ready;
    assign wr_fire   = req_fire && req_write;
    assign wdata     = req_wdata;

    assign eir_wen  = wr_fire && (sel == enet_pkg::SEL_EIR);
    assign eimr_wen = wr_fire && (sel == enet_pkg::SEL_EIMR);
    assign mmfr_wen = wr_fire && (sel == enet_pkg::SEL_MMFR);
    assign mscr_wen = wr_fire && (sel == enet_pkg::SEL_MSCR);
    assign txic_wen = wr_fire && (sel == enet_pkg::SEL_TXIC);
    assign rxic_wen = wr_fire && (sel == enet_pkg::SEL_RXIC);

    // write-one-to-clear on EIR
    assign txf_clear = eir_wen && req_wdata[enet_pkg::EIR_TXF_BIT];
    assign rxf_clear = eir_wen && req_wdata[enet_pkg::EIR_RXF_BIT];

    always_comb begin
        eir = '0;
        eir[enet_pkg::EIR_TXF_BIT] = txf;
        eir[enet_pkg::EIR_RXF_BIT] = rxf;
        eir[enet_pkg::EIR_MII_BIT] = mii;
    end

    assign irq = |(eir & eimr);

    always_comb begin
        case (sel)
            enet_pkg::SEL_EIR:  rdata_mux = eir;
            enet_pkg::SEL_EIMR: rdata_mux = eimr;
            enet_pkg::SEL_MMFR: rdata_mux = mmfr;
            enet_pkg::SEL_MSCR: rdata_mux = mscr;
            enet_pkg::SEL_TXIC: rdata_mux = txic;
            enet_pkg::SEL_RXIC: rdata_mux = rxic;
            default:            rdata_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
            eimr      <= '0;
            mii       <= 1'b0;
        end else begin
            if (req_fire) begin
                rsp_valid <= 1'b1;
            end else if (rsp_ready) begin
                rsp_valid <= 1'b0;
            end
            if (eimr_wen) begin
                eimr <= req_wdata;
            end
            // a finishing frame wins over a clear in the same cycle
            if (mii_done) begin
                mii <= 1'b1;
            end else if (eir_wen && req_wdata[enet_pkg::EIR_MII_BIT]) begin
                mii <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            rsp_rdata <= req_write ? '0 : rdata_mux;
        end
    end

endmodule

// ==== mdio/mdio_if.sv ====
module mdio_if (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        mmfr_wen,
    input  logic                        mscr_wen,
    input  logic [enet_pkg::DATA_W-1:0] wdata,
    input  logic                        mdi,
    output logic [enet_pkg::DATA_W-1:0] mmfr,
    output logic [enet_pkg::DATA_W-1:0] mscr,
    output logic                        done,
    output logic                        mdc,
    output logic                        mdo,
    output logic                        mdo_en
);

    localparam int CNT_W = $clog2(enet_pkg::MDIO_FRAME_BITS);
    localparam logic [CNT_W-1:0] PRE_LAST   = CNT_W'(enet_pkg::MDIO_PRE_BITS - 1);
    localparam logic [CNT_W-1:0] FRAME_LAST = CNT_W'(enet_pkg::MDIO_FRAME_BITS - 1);
    // first bit of turnaround and first bit of data in a read frame
    localparam logic [CNT_W-1:0] TA_FIRST   = CNT_W'(enet_pkg::MDIO_FRAME_BITS
                                              - enet_pkg::MMFR_DATA_W
                                              - enet_pkg::MDIO_TA_BITS);
    localparam logic [CNT_W-1:0] DATA_FIRST = CNT_W'(enet_pkg::MDIO_FRAME_BITS
                                              - enet_pkg::MMFR_DATA_W);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PRE,
        ST_SHIFT
    } state_e;

    state_e                              state;
    logic [enet_pkg::MSCR_SPEED_W-1:0]   speed;
    logic [enet_pkg::MSCR_SPEED_W-1:0]   div_cnt;
    logic [CNT_W-1:0]                    bit_cnt;
    logic [enet_pkg::MDIO_FRAME_BITS-1:0] sh;
    logic                                busy;
    logic                                rd;
    logic                                tick;
    logic                                rise;
    logic                                fall;

    assign speed = mscr[enet_pkg::MSCR_SPEED_LSB +: enet_pkg::MSCR_SPEED_W];
    assign busy  = (state != ST_IDLE);
    assign rd    = (mmfr[enet_pkg::MMFR_OP_LSB +: 2] == enet_pkg::MMFR_OP_READ);
    assign tick  = busy && (div_cnt + 1'b1 >= speed);
    assign rise  = tick && !mdc;
    assign fall  = tick && mdc;

    // mdo only moves with state and sh, which both update on falling mdc
    assign mdo    = (state == ST_SHIFT) ? sh[enet_pkg::MDIO_FRAME_BITS-1] : (state == ST_PRE);
    assign mdo_en = busy && !(rd && (state == ST_SHIFT) && (bit_cnt >= TA_FIRST));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_IDLE;
            mmfr    <= '0;
            mscr    <= '0;
            done    <= 1'b0;
            mdc     <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (mscr_wen) begin
                mscr <= wdata;
            end
            if (!busy) begin
                if (mmfr_wen) begin
                    mmfr <= wdata;
                    if (speed != '0) begin
                        state   <= ST_PRE;
                        div_cnt <= '0;
                        bit_cnt <= '0;
                    end
                end
            end else begin
                if (tick) begin
                    div_cnt <= '0;
                    mdc     <= !mdc;
                end else begin
                    div_cnt <= div_cnt + 1'b1;
                end
                // read data enters MMFR msb first
                if (rise && rd && (state == ST_SHIFT) && (bit_cnt >= DATA_FIRST)) begin
                    mmfr[enet_pkg::MMFR_DATA_W-1:0] <=
                        {mmfr[enet_pkg::MMFR_DATA_W-2:0], mdi};
                end
                if (fall) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (state == ST_PRE && bit_cnt == PRE_LAST) begin
                        state   <= ST_SHIFT;
                        bit_cnt <= '0;
                    end else if (state == ST_SHIFT && bit_cnt == FRAME_LAST) begin
                        state <= ST_IDLE;
                        done  <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fall && state == ST_PRE) begin
            sh <= mmfr;
        end else if (fall && state == ST_SHIFT) begin
            sh <= {sh[enet_pkg::MDIO_FRAME_BITS-2:0], 1'b0};
        end
    end

endmodule

// ==== src/enet_intr_coalesce.sv ====
module enet_intr_coalesce (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        cfg_wen,
    input  logic [enet_pkg::DATA_W-1:0] wdata,
    input  logic                        event_in,
    input  logic                        clear,
    output logic [enet_pkg::DATA_W-1:0] cfg,
    output logic                        flag
);

    logic                         en;
    logic [enet_pkg::IC_FT_W-1:0] ft;
    logic [enet_pkg::IC_FT_W-1:0] ft_eff;
    logic [enet_pkg::IC_TT_W-1:0] tt;
    logic [enet_pkg::IC_FT_W-1:0] frame_cnt;
    logic [enet_pkg::IC_TT_W-1:0] timer;
    logic                         active;
    logic                         cnt_hit;
    logic                         tmr_hit;
    logic                         fire;

    assign en     = cfg[enet_pkg::IC_EN_BIT];
    assign ft     = cfg[enet_pkg::IC_FT_LSB +: enet_pkg::IC_FT_W];
    assign tt     = cfg[enet_pkg::IC_TT_W-1:0];
    // threshold 0 behaves like 1
    assign ft_eff = (ft == '0) ? {{(enet_pkg::IC_FT_W-1){1'b0}}, 1'b1} : ft;

    assign cnt_hit = event_in && (frame_cnt >= ft_eff - 1'b1);
    // timer holds cycles since the first uncounted event, minus one
    assign tmr_hit = active && (tt != '0) && (timer == tt - 1'b1);
    assign fire    = en ? (cnt_hit || tmr_hit) : event_in;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg       <= '0;
            flag      <= 1'b0;
            frame_cnt <= '0;
            timer     <= '0;
            active    <= 1'b0;
        end else begin
            if (cfg_wen) begin
                cfg <= wdata;
            end
            if (fire) begin
                flag <= 1'b1;
            end else if (clear) begin
                flag <= 1'b0;
            end
            if (cfg_wen || fire || !en) begin
                frame_cnt <= '0;
                timer     <= '0;
                active    <= 1'b0;
            end else begin
                if (event_in) begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
                if (active) begin
                    timer <= timer + 1'b1;
                end else if (event_in) begin
                    active <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== common/enet_pkg.sv ====
package enet_pkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 12;

    // register byte offsets
    localparam logic [ADDR_W-1:0] EIR_ADDR  = 12'h004;
    localparam logic [ADDR_W-1:0] EIMR_ADDR = 12'h008;
    localparam logic [ADDR_W-1:0] MMFR_ADDR = 12'h040;
    localparam logic [ADDR_W-1:0] MSCR_ADDR = 12'h044;
    localparam logic [ADDR_W-1:0] TXIC_ADDR = 12'h0F0;
    localparam logic [ADDR_W-1:0] RXIC_ADDR = 12'h100;

    typedef enum logic [2:0] {
        SEL_EIR,
        SEL_EIMR,
        SEL_MMFR,
        SEL_MSCR,
        SEL_TXIC,
        SEL_RXIC,
        SEL_NONE
    } reg_sel_e;

    // event bits in EIR
    localparam int EIR_TXF_BIT = 27;
    localparam int EIR_RXF_BIT = 25;
    localparam int EIR_MII_BIT = 23;

    // TXIC / RXIC fields
    localparam int IC_EN_BIT = 31;
    localparam int IC_FT_LSB = 20;
    localparam int IC_FT_W   = 8;
    localparam int IC_TT_W   = 16;

    localparam int MSCR_SPEED_LSB = 1;
    localparam int MSCR_SPEED_W   = 6;

    // management frame layout
    localparam int MDIO_PRE_BITS   = 32;
    localparam int MDIO_FRAME_BITS = 32;
    localparam int MDIO_TA_BITS    = 2;
    localparam int MMFR_OP_LSB     = 28;
    localparam logic [1:0] MMFR_OP_READ = 2'b10;
    localparam int MMFR_DATA_W     = 16;

endpackage
